//--- str_print_pkg.sv
`default_nettype none

package str_print_pkg;

  // how the stored message is read.
  typedef enum logic {
    MODE_TEXT,
    MODE_HEX
  } str_mode_e;

  typedef enum logic {
    LATCH_IDLE,
    LATCH_BUSY
  } latch_state_e;

  // emit covers every character on offer, last waits for the final frame.
  typedef enum logic [1:0] {
    ITER_IDLE,
    ITER_EMIT,
    ITER_LAST
  } iter_state_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  // base characters of the hex conversion.
  localparam logic [7:0] ascii_zero = 8'h30;
  localparam logic [7:0] ascii_a    = 8'h61;

endpackage

`default_nettype wire

//--- str_msg_latch.sv
`timescale 1ns/1ps
`default_nettype none

module str_msg_latch #(
  parameter int max_str_len = 16,
  localparam int msg_w = 8 * max_str_len,
  localparam int len_w = $clog2(max_str_len + 1),
  localparam int cnt_w = $clog2(2 * max_str_len + 1)
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     s_valid,
  input  logic [msg_w-1:0]         s_msg,
  input  logic                     s_bin,
  input  logic [len_w-1:0]         s_bin_len,
  output logic                     s_ready,

  output logic                     job_start,
  output logic [msg_w-1:0]         job_msg,
  output str_print_pkg::str_mode_e job_mode,
  output logic [cnt_w-1:0]         job_count,
  input  logic                     job_done
);
  import str_print_pkg::*;

  latch_state_e     state;
  logic             accept;
  logic [cnt_w-1:0] text_count;
  logic [cnt_w-1:0] hex_count;
  logic [cnt_w-1:0] new_count;

  assign s_ready = (state == LATCH_IDLE);
  assign accept  = s_valid && s_ready;

  // two characters per binary byte.
  assign hex_count = cnt_w'({s_bin_len, 1'b0});

  // text is right-aligned, so the highest non-zero byte sets the length.
  always_comb begin
    text_count = '0;
    for (int i = 0; i < max_str_len; i++) begin
      if (s_msg[8*i +: 8] != 8'h00) begin
        text_count = cnt_w'(i + 1);
      end
    end
  end

  assign new_count = s_bin ? hex_count : text_count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= LATCH_IDLE;
      job_start <= 1'b0;
    end else begin
      job_start <= 1'b0;
      case (state)
        LATCH_IDLE: begin
          // an empty message is taken but never started.
          if (accept && new_count != '0) begin
            state     <= LATCH_BUSY;
            job_start <= 1'b1;
          end
        end
        LATCH_BUSY: begin
          if (job_done) begin
            state <= LATCH_IDLE;
          end
        end
        default: begin
          state <= LATCH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      job_msg   <= s_msg;
      job_mode  <= s_bin ? MODE_HEX : MODE_TEXT;
      job_count <= new_count;
    end
  end

endmodule

`default_nettype wire

//--- str_char_iter.sv
`timescale 1ns/1ps
`default_nettype none

module str_char_iter #(
  parameter int max_str_len = 16,
  localparam int msg_w = 8 * max_str_len,
  localparam int cnt_w = $clog2(2 * max_str_len + 1)
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     job_start,
  input  logic [msg_w-1:0]         job_msg,
  input  str_print_pkg::str_mode_e job_mode,
  input  logic [cnt_w-1:0]         job_count,
  output logic                     job_done,

  output logic                     char_valid,
  output logic [7:0]               char_data,
  input  logic                     char_ready
);
  import str_print_pkg::*;

  iter_state_e      state;
  logic [cnt_w-1:0] pos;
  logic [cnt_w-1:0] next_pos;
  logic [msg_w-1:0] shifted;
  logic [3:0]       nibble;
  logic [7:0]       next_char;
  logic             xfer;
  logic             load;

  assign char_valid = (state == ITER_EMIT);
  assign xfer       = char_valid && char_ready;

  // the uart raises char_ready again once the final stop bit is out.
  assign job_done = (state == ITER_LAST) && char_ready;

  // pos counts down to zero, the lowest byte or nibble.
  assign next_pos = (state == ITER_IDLE) ? job_count - 1'b1 : pos - 1'b1;
  assign load     = ((state == ITER_IDLE) && job_start) || (xfer && pos != '0);

  always_comb begin
    if (job_mode == MODE_HEX) begin
      shifted = job_msg >> {next_pos, 2'b00};
    end else begin
      shifted = job_msg >> {next_pos, 3'b000};
    end
    nibble = shifted[3:0];
    if (job_mode == MODE_TEXT) begin
      next_char = shifted[7:0];
    end else if (nibble < 4'd10) begin
      next_char = ascii_zero + {4'h0, nibble};
    end else begin
      // lowercase a to f.
      next_char = ascii_a + {4'h0, nibble} - 8'd10;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ITER_IDLE;
    end else begin
      case (state)
        ITER_IDLE: begin
          if (job_start) begin
            state <= ITER_EMIT;
          end
        end
        ITER_EMIT: begin
          if (xfer && pos == '0) begin
            state <= ITER_LAST;
          end
        end
        ITER_LAST: begin
          if (char_ready) begin
            state <= ITER_IDLE;
          end
        end
        default: begin
          state <= ITER_IDLE;
        end
      endcase
    end
  end

  // char_data only moves on a transfer, so it holds under back-pressure.
  always_ff @(posedge clk) begin
    if (load) begin
      pos       <= next_pos;
      char_data <= next_char;
    end
  end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int clks_per_bit = 868,
  localparam int div_w = $clog2(clks_per_bit + 1)
) (
  input  logic       clk,
  input  logic       rst_n,

  input  logic       char_valid,
  input  logic [7:0] char_data,
  output logic       char_ready,

  output logic       txd
);
  import str_print_pkg::*;

  uart_state_e      state;
  logic [div_w-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             bit_done;
  logic             xfer;

  assign char_ready = (state == UART_IDLE);
  assign xfer       = char_valid && char_ready;
  assign bit_done   = (clk_cnt == div_w'(clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= UART_IDLE;
      txd     <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        UART_IDLE: begin
          if (xfer) begin
            txd     <= 1'b0;
            clk_cnt <= '0;
            state   <= UART_START;
          end
        end
        UART_START: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= shift[0];
            state   <= UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              txd   <= 1'b1;
              state <= UART_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              // shift[1] is the bit that moves into place this edge.
              txd     <= shift[1];
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          if (bit_done) begin
            clk_cnt <= '0;
            state   <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          state <= UART_IDLE;
        end
      endcase
    end
  end

  // lsb first.
  always_ff @(posedge clk) begin
    if (xfer) begin
      shift <= char_data;
    end else if (state == UART_DATA && bit_done) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- str_print.sv
`timescale 1ns/1ps
`default_nettype none

module str_print #(
  parameter int max_str_len  = 16,
  parameter int clks_per_bit = 868,
  localparam int msg_w = 8 * max_str_len,
  localparam int len_w = $clog2(max_str_len + 1),
  localparam int cnt_w = $clog2(2 * max_str_len + 1)
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             s_valid,
  input  logic [msg_w-1:0] s_msg,
  input  logic             s_bin,
  input  logic [len_w-1:0] s_bin_len,
  output logic             s_ready,

  output logic             txd
);
  import str_print_pkg::*;

  logic             job_start;
  logic [msg_w-1:0] job_msg;
  str_mode_e        job_mode;
  logic [cnt_w-1:0] job_count;
  logic             job_done;

  logic             char_valid;
  logic [7:0]       char_data;
  logic             char_ready;

  str_msg_latch #(
    .max_str_len(max_str_len)
  ) u_latch (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_msg     (s_msg),
    .s_bin     (s_bin),
    .s_bin_len (s_bin_len),
    .s_ready   (s_ready),
    .job_start (job_start),
    .job_msg   (job_msg),
    .job_mode  (job_mode),
    .job_count (job_count),
    .job_done  (job_done)
  );

  str_char_iter #(
    .max_str_len(max_str_len)
  ) u_iter (
    .clk        (clk),
    .rst_n      (rst_n),
    .job_start  (job_start),
    .job_msg    (job_msg),
    .job_mode   (job_mode),
    .job_count  (job_count),
    .job_done   (job_done),
    .char_valid (char_valid),
    .char_data  (char_data),
    .char_ready (char_ready)
  );

  uart_tx #(
    .clks_per_bit(clks_per_bit)
  ) u_uart (
    .clk        (clk),
    .rst_n      (rst_n),
    .char_valid (char_valid),
    .char_data  (char_data),
    .char_ready (char_ready),
    .txd        (txd)
  );

endmodule

`default_nettype wire

//--- str_print_props.sv
`timescale 1ns/1ps
`default_nettype none

module str_print_props #(
  parameter int max_str_len = 16,
  localparam int cnt_w = $clog2(2 * max_str_len + 1)
) (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        s_ready,
  input logic                        txd,
  input logic                        job_start,
  input logic [cnt_w-1:0]            job_count,
  input logic                        char_valid,
  input logic                        char_ready,
  input logic [7:0]                  char_data,
  input str_print_pkg::latch_state_e latch_state,
  input str_print_pkg::uart_state_e  uart_state
);
  import str_print_pkg::*;

  // the host port stays closed while any character is pending or on the line.
  busy_blocks_host: assert property (
    @(posedge clk) disable iff (!rst_n)
      (char_valid || uart_state != UART_IDLE) |-> (latch_state == LATCH_BUSY && !s_ready)
  ) else $error("s_ready high while a job is still being sent");

  idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n) (uart_state == UART_IDLE) |-> txd
  ) else $error("txd low while the uart is idle");

  // a stalled character keeps its value until the uart takes it.
  char_held: assert property (
    @(posedge clk) disable iff (!rst_n)
      (char_valid && !char_ready) |=> (char_valid && $stable(char_data))
  ) else $error("char_data or char_valid moved under back-pressure");

  no_empty_job: assert property (
    @(posedge clk) disable iff (!rst_n) job_start |-> (job_count != '0)
  ) else $error("job started with a zero character count");

endmodule

bind str_print str_print_props #(
  .max_str_len(max_str_len)
) u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .s_ready     (s_ready),
  .txd         (txd),
  .job_start   (job_start),
  .job_count   (job_count),
  .char_valid  (char_valid),
  .char_ready  (char_ready),
  .char_data   (char_data),
  .latch_state (u_latch.state),
  .uart_state  (u_uart.state)
);

`default_nettype wire

//--- str_print_tb.sv
`timescale 1ns/1ps
`default_nettype none

module str_print_tb;

  localparam int max_str_len  = 16;
  localparam int clks_per_bit = 8;
  localparam int msg_w        = 8 * max_str_len;
  localparam int len_w        = $clog2(max_str_len + 1);
  localparam int num_rows     = 10;

  logic             clk;
  logic             rst_n;
  logic             s_valid;
  logic [msg_w-1:0] s_msg;
  logic             s_bin;
  logic [len_w-1:0] s_bin_len;
  logic             s_ready;
  logic             txd;

  // stimulus table, one entry per message.
  logic             row_bin [num_rows];
  int               row_len [num_rows];
  logic [msg_w-1:0] row_msg [num_rows];
  string            row_exp [num_rows];
  int               row_gap [num_rows];

  logic [7:0]  rx_chars[$];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          cycles;
  int          cycle_limit;

  str_print #(
    .max_str_len  (max_str_len),
    .clks_per_bit (clks_per_bit)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_msg     (s_msg),
    .s_bin     (s_bin),
    .s_bin_len (s_bin_len),
    .s_ready   (s_ready),
    .txd       (txd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL @ %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // right-aligned, the first character lands in the highest used byte.
  function automatic logic [msg_w-1:0] pack_text(input string s);
    logic [msg_w-1:0] v;
    v = '0;
    for (int i = 0; i < s.len(); i++) begin
      v[8*(s.len()-1-i) +: 8] = s[i];
    end
    return v;
  endfunction

  // most significant nibble first, lowercase digits.
  function automatic string hex_string(input logic [msg_w-1:0] v, input int nbytes);
    string s;
    s = "";
    for (int i = 2 * nbytes - 1; i >= 0; i--) begin
      s = {s, $sformatf("%h", v[4*i +: 4])};
    end
    return s;
  endfunction

  task automatic set_row(input int r, input logic bin, input int len,
                         input logic [msg_w-1:0] msg, input string exp, input int gap);
    row_bin[r] = bin;
    row_len[r] = len;
    row_msg[r] = msg;
    row_exp[r] = exp;
    row_gap[r] = gap;
  endtask

  task automatic build_table();
    logic [msg_w-1:0] rnd;
    set_row(0, 1'b0, 0, pack_text("Hello"), "Hello", 2);
    set_row(1, 1'b0, 0, pack_text("Test123"), "Test123", 3);
    set_row(2, 1'b0, 0, pack_text("Full sixteen chr"), "Full sixteen chr", 2);
    // empty, so the next row has to go in at once.
    set_row(3, 1'b0, 0, '0, "", 0);
    set_row(4, 1'b1, 2, msg_w'(16'hcafe), "cafe", 2);
    set_row(5, 1'b1, 8, msg_w'(64'hcafe0000babef00d), "cafe0000babef00d", 1);
    // upper random bytes lie outside bin_len and must be ignored.
    rnd = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    set_row(6, 1'b1, 5, rnd, hex_string(rnd, 5), 2);
    rnd = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    set_row(7, 1'b1, 16, rnd, hex_string(rnd, 16), 2);
    set_row(8, 1'b0, 0, pack_text("First"), "First", 0);
    set_row(9, 1'b0, 0, pack_text("Second"), "Second", 2);
  endtask

  // s_ready only moves on rising edges, so a falling-edge look is safe.
  task automatic send_rows();
    for (int r = 0; r < num_rows; r++) begin
      s_valid   = 1'b1;
      s_bin     = row_bin[r];
      s_bin_len = len_w'(row_len[r]);
      s_msg     = row_msg[r];
      while (!s_ready) begin
        @(negedge clk);
      end
      @(negedge clk);
      if (row_exp[r].len() == 0) begin
        check($sformatf("row %0d s_ready after empty message", r), int'(s_ready), 1);
      end else begin
        check($sformatf("row %0d s_ready after accept", r), int'(s_ready), 0);
      end
      if (row_gap[r] > 0) begin
        s_valid = 1'b0;
        repeat (row_gap[r]) @(negedge clk);
      end
    end
    s_valid = 1'b0;
  endtask

  // a job ends when s_ready rises, after the last stop bit.
  task automatic check_strings();
    for (int r = 0; r < num_rows; r++) begin
      if (row_exp[r].len() != 0) begin
        while (s_ready) begin
          @(negedge clk);
        end
        while (!s_ready) begin
          @(negedge clk);
        end
        check($sformatf("row %0d length", r), rx_chars.size(), row_exp[r].len());
        for (int i = 0; i < row_exp[r].len() && i < rx_chars.size(); i++) begin
          check($sformatf("row %0d char %0d", r, i), rx_chars[i], row_exp[r][i]);
        end
        check($sformatf("row %0d txd idle after message", r), int'(txd), 1);
        rx_chars.delete();
      end
    end
  endtask

  initial begin : uart_decoder
    logic [7:0] ch;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (txd == 1'b0) begin
        // move to mid-bit of the start bit.
        repeat (clks_per_bit / 2 - 1) @(negedge clk);
        check("start bit", int'(txd), 0);
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          ch[i] = txd;
        end
        repeat (clks_per_bit) @(negedge clk);
        check("stop bit", int'(txd), 1);
        rx_chars.push_back(ch);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the printer did not finish", cycles);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    rst_n       = 1'b0;
    s_valid     = 1'b0;
    s_msg       = '0;
    s_bin       = 1'b0;
    s_bin_len   = '0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    lcg_state   = 32'd64869;
    build_table();
    cycle_limit = 200;
    for (int r = 0; r < num_rows; r++) begin
      cycle_limit += row_exp[r].len() * 10 * clks_per_bit * 2;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check("txd after reset", int'(txd), 1);
    check("s_ready after reset", int'(s_ready), 1);
    fork
      send_rows();
      check_strings();
    join
    // nothing may follow the last message.
    repeat (12 * clks_per_bit) @(negedge clk);
    check("characters after last message", rx_chars.size(), 0);
    check("txd idle at end", int'(txd), 1);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- str_print.f
str_print_pkg.sv
str_msg_latch.sv
str_char_iter.sv
uart_tx.sv
str_print.sv
str_print_props.sv
str_print_tb.sv

//--- Makefile
# Verilator build and run of the string printer testbench.

VERILATOR ?= verilator
TOP       ?= str_print_tb
FILELIST  ?= str_print.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  echo "simulation PASSED"; \
	else \
	  echo "simulation FAILED"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
